// ==== board/board_store.sv ====
`timescale 1ns/1ps

module board_store
    import game_pkg::*;
#(
    parameter int board_width = 10
) (
    input  logic    clock,
    input  logic    rst_n,
    input  coord_t  a_h,
    input  coord_t  a_v,
    input  coord_t  b_h,
    input  coord_t  b_v,
    input  logic    src_we,
    input  logic    dst_we,
    input  player_t wr_owner,
    input  troop_t  src_troop,
    input  troop_t  dst_troop,
    output player_t a_owner,
    output piece_t  a_piece,
    output troop_t  a_troop,
    output player_t b_owner,
    output piece_t  b_piece,
    output troop_t  b_troop
);

    // indexed [h][v]
    player_t owner_q [board_width][board_width];
    troop_t  troop_q [board_width][board_width];

    function automatic logic is_red_crown(coord_t h, coord_t v);
        return (h == RED_CROWN_H) && (v == RED_CROWN_V);
    endfunction

    function automatic logic is_blue_crown(coord_t h, coord_t v);
        return (h == BLUE_CROWN_H) && (v == BLUE_CROWN_V);
    endfunction

    // piece types never change, so they come straight from the layout
    function automatic piece_t piece_at(coord_t h, coord_t v);
        if (is_red_crown(h, v) || is_blue_crown(h, v)) begin
            return crown;
        end
        if (h == MOUNTAIN_H && v == MOUNTAIN_V) begin
            return mountain;
        end
        if (h == CITY_H && v == CITY_V) begin
            return city;
        end
        return territory;
    endfunction

    function automatic player_t start_owner(coord_t h, coord_t v);
        if (is_red_crown(h, v)) begin
            return red;
        end
        if (is_blue_crown(h, v)) begin
            return blue;
        end
        return npc;  // mountain and city too
    endfunction

    function automatic troop_t start_troop(coord_t h, coord_t v);
        if (is_red_crown(h, v)) begin
            return RED_CROWN_TROOP;
        end
        if (is_blue_crown(h, v)) begin
            return BLUE_CROWN_TROOP;
        end
        if (h == CITY_H && v == CITY_V) begin
            return CITY_TROOP;
        end
        return '0;
    endfunction

    assign a_owner = owner_q[a_h][a_v];
    assign a_piece = piece_at(a_h, a_v);
    assign a_troop = troop_q[a_h][a_v];
    assign b_owner = owner_q[b_h][b_v];
    assign b_piece = piece_at(b_h, b_v);
    assign b_troop = troop_q[b_h][b_v];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int h = 0; h < board_width; h++) begin
                for (int v = 0; v < board_width; v++) begin
                    owner_q[h][v] <= start_owner(coord_t'(h), coord_t'(v));
                    troop_q[h][v] <= start_troop(coord_t'(h), coord_t'(v));
                end
            end
        end else begin
            if (src_we) begin  // source cell sits at port a
                owner_q[a_h][a_v] <= wr_owner;
                troop_q[a_h][a_v] <= src_troop;
            end
            if (dst_we) begin  // target at port b
                owner_q[b_h][b_v] <= wr_owner;
                troop_q[b_h][b_v] <= dst_troop;
            end
        end
    end

    // a move always lands on a neighbour, never on its own source
    a_no_write_overlap: assert property (
        @(posedge clock) disable iff (!rst_n)
        (src_we && dst_we) |-> (a_h != b_h || a_v != b_v)
    );

endmodule

// ==== common/game_pkg.sv ====
package game_pkg;

    // owner of a cell, also the player whose turn it is
    typedef enum logic [1:0] {
        npc,
        red,
        blue
    } player_t;

    typedef enum logic [1:0] {
        territory,  // plain land, empty cells included
        mountain,
        crown,
        city
    } piece_t;

    // bit 1 set means a move mode
    typedef enum logic [1:0] {
        choose     = 2'b00,
        move_total = 2'b10,
        move_half  = 2'b11
    } cursor_mode_t;

    // keyboard codes 6 and 7 carry no operation
    typedef enum logic [2:0] {
        op_up    = 3'd0,
        op_left  = 3'd1,
        op_down  = 3'd2,
        op_right = 3'd3,
        op_space = 3'd4,
        op_z     = 3'd5
    } key_op_t;

    typedef logic [3:0] coord_t;  // boards up to 16 wide
    typedef logic [8:0] troop_t;

    // fixed cells of the start layout
    localparam coord_t RED_CROWN_H  = 4'd2;
    localparam coord_t RED_CROWN_V  = 4'd3;
    localparam coord_t BLUE_CROWN_H = 4'd8;
    localparam coord_t BLUE_CROWN_V = 4'd7;

    localparam troop_t RED_CROWN_TROOP  = 9'd87;
    localparam troop_t BLUE_CROWN_TROOP = 9'd89;

    localparam coord_t MOUNTAIN_H = 4'd4;
    localparam coord_t MOUNTAIN_V = 4'd3;

    localparam coord_t CITY_H     = 4'd2;
    localparam coord_t CITY_V     = 4'd5;
    localparam troop_t CITY_TROOP = 9'd40;

endpackage

// ==== compile.f ====
common/game_pkg.sv
design/key_command_latch.sv
board/board_store.sv
engine/move_engine.sv
design/game_player_top.sv
verif/game_player_tb.sv

// ==== design/game_player_top.sv ====
`timescale 1ns/1ps

module game_player_top
    import game_pkg::*;
#(
    parameter int board_width = 10
) (
    input  logic         clock,
    input  logic         rst_n,
    input  logic         keyboard_ready,
    input  logic [2:0]   keyboard_data,
    output logic         keyboard_read_fin,
    output coord_t       cursor_h,
    output coord_t       cursor_v,
    output cursor_mode_t cursor_mode,
    output player_t      current_player,
    output player_t      cell_owner,
    output piece_t       cell_piece,
    output troop_t       cell_troop
);

    logic    op_valid;
    key_op_t op_code;
    logic    op_hold;
    logic    op_taken;

    coord_t  a_h;
    coord_t  a_v;
    coord_t  b_h;
    coord_t  b_v;
    logic    src_we;
    logic    dst_we;
    player_t wr_owner;
    troop_t  src_troop;
    troop_t  dst_troop;
    player_t b_owner;
    piece_t  b_piece;
    troop_t  b_troop;

    key_command_latch u_key_command_latch (
        .clock             (clock),
        .rst_n             (rst_n),
        .keyboard_ready    (keyboard_ready),
        .keyboard_data     (keyboard_data),
        .op_taken          (op_taken),
        .keyboard_read_fin (keyboard_read_fin),
        .op_valid          (op_valid),
        .op_code           (op_code),
        .op_hold           (op_hold)
    );

    // port a follows the cursor, so it also feeds the cell outputs
    board_store #(
        .board_width (board_width)
    ) u_board_store (
        .clock     (clock),
        .rst_n     (rst_n),
        .a_h       (a_h),
        .a_v       (a_v),
        .b_h       (b_h),
        .b_v       (b_v),
        .src_we    (src_we),
        .dst_we    (dst_we),
        .wr_owner  (wr_owner),
        .src_troop (src_troop),
        .dst_troop (dst_troop),
        .a_owner   (cell_owner),
        .a_piece   (cell_piece),
        .a_troop   (cell_troop),
        .b_owner   (b_owner),
        .b_piece   (b_piece),
        .b_troop   (b_troop)
    );

    move_engine #(
        .board_width (board_width)
    ) u_move_engine (
        .clock          (clock),
        .rst_n          (rst_n),
        .op_valid       (op_valid),
        .op_code        (op_code),
        .op_hold        (op_hold),
        .a_owner        (cell_owner),
        .a_piece        (cell_piece),
        .a_troop        (cell_troop),
        .b_owner        (b_owner),
        .b_piece        (b_piece),
        .b_troop        (b_troop),
        .op_taken       (op_taken),
        .a_h            (a_h),
        .a_v            (a_v),
        .b_h            (b_h),
        .b_v            (b_v),
        .src_we         (src_we),
        .dst_we         (dst_we),
        .wr_owner       (wr_owner),
        .src_troop      (src_troop),
        .dst_troop      (dst_troop),
        .cursor_h       (cursor_h),
        .cursor_v       (cursor_v),
        .cursor_mode    (cursor_mode),
        .current_player (current_player)
    );

endmodule

// ==== design/key_command_latch.sv ====
`timescale 1ns/1ps

module key_command_latch
    import game_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       keyboard_ready,
    input  logic [2:0] keyboard_data,
    input  logic       op_taken,
    output logic       keyboard_read_fin,
    output logic       op_valid,
    output key_op_t    op_code,
    output logic       op_hold
);

    logic code_is_op;

    // codes 6 and 7 are acked but never stored
    assign code_is_op = (keyboard_data <= 3'(op_z));

    // keyboard side has priority, engine waits while a key is offered
    assign op_hold = keyboard_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            keyboard_read_fin <= 1'b0;
            op_valid          <= 1'b0;
        end else begin
            keyboard_read_fin <= keyboard_ready;  // one ack per offered cycle
            if (keyboard_ready && code_is_op) begin
                op_valid <= 1'b1;
            end else if (op_taken) begin
                op_valid <= 1'b0;
            end
        end
    end

    // single slot, newest key overwrites a pending one
    always_ff @(posedge clock) begin
        if (keyboard_ready && code_is_op) begin
            op_code <= key_op_t'(keyboard_data);
        end
    end

    // the engine may only consume what the latch holds
    a_taken_needs_valid: assert property (
        @(posedge clock) disable iff (!rst_n)
        op_taken |-> op_valid
    );

endmodule

// ==== engine/move_engine.sv ====
`timescale 1ns/1ps

module move_engine
    import game_pkg::*;
#(
    parameter int board_width = 10
) (
    input  logic         clock,
    input  logic         rst_n,
    input  logic         op_valid,
    input  key_op_t      op_code,
    input  logic         op_hold,
    input  player_t      a_owner,
    input  piece_t       a_piece,
    input  troop_t       a_troop,
    input  player_t      b_owner,
    input  piece_t       b_piece,
    input  troop_t       b_troop,
    output logic         op_taken,
    output coord_t       a_h,
    output coord_t       a_v,
    output coord_t       b_h,
    output coord_t       b_v,
    output logic         src_we,
    output logic         dst_we,
    output player_t      wr_owner,
    output troop_t       src_troop,
    output troop_t       dst_troop,
    output coord_t       cursor_h,
    output coord_t       cursor_v,
    output cursor_mode_t cursor_mode,
    output player_t      current_player
);

    localparam coord_t LAST_IDX = coord_t'(board_width - 1);

    logic    execute;
    logic    is_dir;
    logic    off_board;
    coord_t  tgt_h;
    coord_t  tgt_v;
    logic    can_enter;
    logic    target_open;
    logic    do_move;
    troop_t  half_troop;
    player_t next_player;
    coord_t  crown_h;
    coord_t  crown_v;

    // one operation per edge, and only once the keyboard has let go
    assign execute  = op_valid && !op_hold;
    assign op_taken = execute;

    assign is_dir = (op_code == op_up) || (op_code == op_left) ||
                    (op_code == op_down) || (op_code == op_right);

    // neighbour in the key direction, held at the cursor when off board
    always_comb begin
        tgt_h     = cursor_h;
        tgt_v     = cursor_v;
        off_board = 1'b1;  // space and z have no target
        case (op_code)
            op_up: begin
                off_board = (cursor_v == '0);
                if (!off_board) tgt_v = cursor_v - coord_t'(1);
            end
            op_left: begin
                off_board = (cursor_h == '0);
                if (!off_board) tgt_h = cursor_h - coord_t'(1);
            end
            op_down: begin
                off_board = (cursor_v == LAST_IDX);
                if (!off_board) tgt_v = cursor_v + coord_t'(1);
            end
            op_right: begin
                off_board = (cursor_h == LAST_IDX);
                if (!off_board) tgt_h = cursor_h + coord_t'(1);
            end
            default: ;
        endcase
    end

    assign a_h = cursor_h;
    assign a_v = cursor_v;
    assign b_h = tgt_h;
    assign b_v = tgt_v;

    assign can_enter = (a_owner == current_player) && (a_troop >= troop_t'(2));

    // only neutral land or a neutral city can be taken for now
    assign target_open = !off_board && (b_owner == npc) &&
                         ((b_piece == territory) || (b_piece == city));

    assign do_move = execute && (cursor_mode != choose) && is_dir && target_open;

    assign half_troop = a_troop >> 1;

    always_comb begin
        if (cursor_mode == move_half) begin
            dst_troop = half_troop;
            src_troop = a_troop - half_troop;  // odd troop stays behind
        end else begin
            dst_troop = a_troop - troop_t'(1);
            src_troop = troop_t'(1);
        end
    end

    assign src_we   = do_move;
    assign dst_we   = do_move;
    assign wr_owner = current_player;

    assign next_player = (current_player == red) ? blue : red;
    assign crown_h     = (next_player == red) ? RED_CROWN_H : BLUE_CROWN_H;
    assign crown_v     = (next_player == red) ? RED_CROWN_V : BLUE_CROWN_V;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            cursor_h       <= '0;
            cursor_v       <= '0;
            cursor_mode    <= choose;
            current_player <= red;
        end else if (execute) begin
            case (cursor_mode)
                choose: begin
                    if (is_dir && !off_board) begin
                        cursor_h <= tgt_h;
                        cursor_v <= tgt_v;
                    end else if (op_code == op_space && can_enter) begin
                        cursor_mode <= move_total;
                    end
                end
                move_total, move_half: begin
                    if (is_dir) begin
                        // turn passes whether or not the move went through
                        current_player <= next_player;
                        cursor_h       <= crown_h;
                        cursor_v       <= crown_v;
                        cursor_mode    <= choose;
                    end else if (op_code == op_space) begin
                        cursor_mode <= choose;
                    end else if (op_code == op_z) begin
                        cursor_mode <= (cursor_mode == move_total) ? move_half : move_total;
                    end
                end
                default: cursor_mode <= choose;
            endcase
        end
    end

    a_cursor_on_board: assert property (
        @(posedge clock) disable iff (!rst_n)
        (cursor_h <= LAST_IDX) && (cursor_v <= LAST_IDX)
    );

    a_choose_after_reset: assert property (
        @(posedge clock)
        $rose(rst_n) |-> (cursor_mode == choose)
    );

    // in move mode the cursor sits on a cell of the player, never a mountain
    a_move_source_owned: assert property (
        @(posedge clock) disable iff (!rst_n)
        (cursor_mode != choose) |-> (a_owner == current_player && a_piece != mountain)
    );

    // the target troop count only matters to a renderer; taken cells stay empty
    a_open_target_empty: assert property (
        @(posedge clock) disable iff (!rst_n)
        do_move && (b_piece == territory) |-> (b_troop == '0)
    );

endmodule

// ==== verif/game_player_input.txt ====
# name key cursor_h cursor_v mode(0 choose 2 total 3 half) player(1 red 2 blue)
# then cell_owner(0 npc) cell_piece(0 territory 1 mountain 2 crown 3 city) cell_troop
up_clamp 0 0 0 0 1 0 0 0
left_clamp 1 0 0 0 1 0 0 0
code6_ignored 6 0 0 0 1 0 0 0
step_right 3 1 0 0 1 0 0 0
step_down 2 1 1 0 1 0 0 0
space_on_neutral 4 1 1 0 1 0 0 0
step_right_2 3 2 1 0 1 0 0 0
step_down_2 2 2 2 0 1 0 0 0
reach_red_crown 2 2 3 0 1 1 2 87
enter_move_total 4 2 3 2 1 1 2 87
total_move_right 3 8 7 0 2 2 2 89
blue_enter_move 4 8 7 2 2 2 2 89
toggle_to_half 5 8 7 3 2 2 2 89
toggle_to_total 5 8 7 2 2 2 2 89
toggle_half_again 5 8 7 3 2 2 2 89
half_move_up 0 2 3 0 1 1 2 1
space_low_troop 4 2 3 0 1 1 2 1
view_total_target 3 3 3 0 1 1 0 86
enter_at_target 4 3 3 2 1 1 0 86
move_onto_mountain 3 8 7 0 2 2 2 45
blue_enter_again 4 8 7 2 2 2 2 45
blocked_by_own_cell 0 2 3 0 1 1 2 1
source_unchanged 3 3 3 0 1 1 0 86
view_mountain 3 4 3 0 1 0 1 0
back_to_source 1 3 3 0 1 1 0 86
enter_for_down 4 3 3 2 1 1 0 86
total_move_down 2 8 7 0 2 2 2 45
view_half_target 0 8 6 0 2 2 0 44
step_to_edge 3 9 6 0 2 0 0 0
right_clamp 3 9 6 0 2 0 0 0
back_from_edge 1 8 6 0 2 2 0 44
blue_enter_half_tgt 4 8 6 2 2 2 0 44
blue_move_onto_crown 2 2 3 0 1 1 2 1
step_to_source 3 3 3 0 1 1 0 1
step_to_new_cell 2 3 4 0 1 1 0 85
enter_at_new_cell 4 3 4 2 1 1 0 85
total_move_left 1 8 7 0 2 2 2 45
blue_enter_third 4 8 7 2 2 2 2 45
blue_pass_up 0 2 3 0 1 1 2 1
step_down_to_84 2 2 4 0 1 1 0 84
enter_next_to_city 4 2 4 2 1 1 0 84
capture_city 2 8 7 0 2 2 2 45
blue_enter_last 4 8 7 2 2 2 2 45
blue_pass_last 0 2 3 0 1 1 2 1
step_over_source 2 2 4 0 1 1 0 1
view_captured_city 2 2 5 0 1 1 3 83

// ==== verif/game_player_tb.sv ====
`timescale 1ns/1ps

module game_player_tb;

    logic       clock;
    logic       rst_n;
    logic       keyboard_ready;
    logic [2:0] keyboard_data;
    logic       keyboard_read_fin;
    logic [3:0] cursor_h;
    logic [3:0] cursor_v;
    logic [1:0] cursor_mode;
    logic [1:0] current_player;
    logic [1:0] cell_owner;
    logic [1:0] cell_piece;
    logic [8:0] cell_troop;

    int pass_count;
    int fail_count;
    int field_errors;
    bit run_aborted;

    game_player_top #(
        .board_width (10)
    ) u_game_player_top (
        .clock             (clock),
        .rst_n             (rst_n),
        .keyboard_ready    (keyboard_ready),
        .keyboard_data     (keyboard_data),
        .keyboard_read_fin (keyboard_read_fin),
        .cursor_h          (cursor_h),
        .cursor_v          (cursor_v),
        .cursor_mode       (cursor_mode),
        .current_player    (current_player),
        .cell_owner        (cell_owner),
        .cell_piece        (cell_piece),
        .cell_troop        (cell_troop)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;  // 100 ns period
    end

    task automatic compare_field(input string test_name, input string field,
                                 input int expected, input int actual);
        assert (actual == expected) else begin
            $display("ERR %s %s expected %0d actual %0d", test_name, field, expected, actual);
            field_errors++;
        end
    endtask

    // offer one key for a cycle, then wait for the edge that executes it
    task automatic offer_key(input int key_code, output bit acked);
        int waited;
        waited = 0;
        acked = 1'b0;
        @(posedge clock);
        #5;
        keyboard_ready = 1'b1;
        keyboard_data  = 3'(key_code);
        while (!acked && waited < 20) begin
            @(posedge clock);
            #5;
            if (keyboard_read_fin) begin
                acked = 1'b1;
            end
            waited++;
        end
        keyboard_ready = 1'b0;
        keyboard_data  = 3'd7;  // no operation
        if (acked) begin
            @(posedge clock);  // latch releases op_hold, engine executes here
            #5;
        end
    endtask

    initial begin : stimulus
        int    fd;
        int    fields;
        string line;
        string test_name;
        int    key_code;
        int    exp_h;
        int    exp_v;
        int    exp_mode;
        int    exp_player;
        int    exp_owner;
        int    exp_piece;
        int    exp_troop;
        bit    acked;

        rst_n          = 1'b0;
        keyboard_ready = 1'b0;
        keyboard_data  = 3'd7;
        pass_count     = 0;
        fail_count     = 0;
        field_errors   = 0;
        run_aborted    = 1'b0;

        repeat (10) @(posedge clock);
        #5;
        rst_n = 1'b1;

        fd = $fopen("verif/game_player_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verif/game_player_input.txt");
            run_aborted = 1'b1;
        end

        while (fd != 0 && !run_aborted && !$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;  // header lines
            end
            fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d", test_name, key_code,
                             exp_h, exp_v, exp_mode, exp_player, exp_owner,
                             exp_piece, exp_troop);
            if (fields <= 0) begin
                continue;  // blank line
            end
            if (fields != 9) begin
                $display("stimulus line could not be parsed: %s", line);
                fail_count++;
                continue;
            end

            offer_key(key_code, acked);
            if (!acked) begin
                $display("keyboard_read_fin never rose in %s", test_name);
                fail_count++;
                run_aborted = 1'b1;
                break;
            end

            field_errors = 0;
            compare_field(test_name, "cursor_h", exp_h, int'(cursor_h));
            compare_field(test_name, "cursor_v", exp_v, int'(cursor_v));
            compare_field(test_name, "cursor_mode", exp_mode, int'(cursor_mode));
            compare_field(test_name, "current_player", exp_player, int'(current_player));
            compare_field(test_name, "cell_owner", exp_owner, int'(cell_owner));
            compare_field(test_name, "cell_piece", exp_piece, int'(cell_piece));
            compare_field(test_name, "cell_troop", exp_troop, int'(cell_troop));
            // ack drops again after an edge with ready low
            compare_field(test_name, "keyboard_read_fin", 0, int'(keyboard_read_fin));

            if (field_errors == 0) begin
                pass_count++;
                $display("%s ok", test_name);
            end else begin
                fail_count++;
                $display("%s mismatch", test_name);
            end
        end

        if (fd != 0) begin
            $fclose(fd);
        end

        $display("%0d tests ok, %0d tests with errors", pass_count, fail_count);
        if (fail_count == 0 && !run_aborted && pass_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
